// ==== rtl/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

    typedef logic [13:0] vic_addr_t;
    typedef logic [11:0] dram_addr_t;
    typedef logic [9:0]  vc_t;
    typedef logic [2:0]  rc_t;
    typedef logic [7:0]  refc_t;
    typedef logic [7:0]  data_t;
    typedef logic [7:0]  sprite_ptr_t;
    typedef logic [2:0]  sprite_idx_t;
    typedef logic [5:0]  sprite_mc_t;
    typedef logic [1:0]  tick_t;
    typedef logic [5:0]  cycle_t;   // cycle within line
    typedef logic [8:0]  line_t;    // raster line
    typedef logic [5:0]  col_t;     // matrix line index

    localparam int NUM_SPRITES     = 8;
    localparam int NUM_COLS        = 40;
    localparam int CYCLES_PER_LINE = 63;

    // schedule, in cycles of the line
    localparam int REF_LAST        = 4;
    localparam int C_FIRST         = 4;
    localparam int C_LAST          = 43;
    localparam int G_FIRST         = 5;
    localparam int G_LAST          = 44;
    localparam int SPR_FIRST       = 46;
    localparam int SPR_LAST        = 61;
    localparam int VC_RELOAD_CYCLE = 14;
    localparam int RC_STEP_CYCLE   = 58;
    localparam int BA_LEAD         = 3;   // ba warning, in cycles

    localparam vic_addr_t IDLE_ADDR     = 14'h3fff;
    localparam vic_addr_t IDLE_ECM_ADDR = 14'h39ff;

    typedef enum logic [2:0] {
        VIC_LR,     // refresh
        VIC_LG,     // g-access
        VIC_HRC,    // c-access, steals phi2
        VIC_LP,     // sprite pointer
        VIC_HS1,
        VIC_LS2,
        VIC_HS3,
        VIC_NONE
    } cycle_kind_e;

    typedef struct packed {
        logic [3:0] vm;
        logic [2:0] cb;
        logic       bmm;
        logic       ecm;
        logic       den;
        logic [2:0] yscroll;
        logic [7:0] spr_en;
    } vic_regs_s;

    typedef struct packed {
        cycle_kind_e            kind;
        tick_t                  tick;
        cycle_t                 cycle;
        sprite_idx_t            sprite;
        refc_t                  refc;
        logic [NUM_SPRITES-1:0] spr_en;
        logic                   bad_line;
        logic                   frame_start;
        logic                   line_start;
    } slot_s;

    // row half first, then column half
    function automatic dram_addr_t dram_row(input vic_addr_t a);
        return {a[11:8], 2'b11, a[13:8]};
    endfunction

    function automatic dram_addr_t dram_col(input vic_addr_t a);
        return {a[11:8], a[7:0]};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/vic_cycle_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_cycle_seq #(
    parameter int NUM_LINES  = 312,
    parameter int DISP_FIRST = 48,
    parameter int DISP_LAST  = 247
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire vic_pkg::vic_regs_s  regs_i,
    output vic_pkg::slot_s           slot_o
);

    vic_pkg::tick_t  tick_q;
    vic_pkg::cycle_t cyc_q;
    vic_pkg::line_t  line_q;
    vic_pkg::refc_t  refc_q;
    vic_pkg::cycle_t spr_off;
    logic            line_end;
    logic            frame_end;
    logic            bad_line;
    logic            spr_range;

    assign line_end  = (tick_q == 2'd3) && (cyc_q == vic_pkg::CYCLES_PER_LINE - 1);
    assign frame_end = line_end && (line_q == NUM_LINES - 1);

    assign bad_line = regs_i.den
                   && (line_q >= DISP_FIRST) && (line_q <= DISP_LAST)
                   && (line_q[2:0] == regs_i.yscroll);

    assign spr_range = (cyc_q >= vic_pkg::SPR_FIRST) && (cyc_q <= vic_pkg::SPR_LAST);
    assign spr_off   = cyc_q - vic_pkg::cycle_t'(vic_pkg::SPR_FIRST);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tick_q <= '0;
            cyc_q  <= '0;
            line_q <= '0;
            refc_q <= '1;
        end else begin
            tick_q <= tick_q + 1'b1;
            if (line_end) begin
                cyc_q  <= '0;
                line_q <= frame_end ? '0 : line_q + 1'b1;
            end else if (tick_q == 2'd3) begin
                cyc_q <= cyc_q + 1'b1;
            end

            if (frame_end)
                refc_q <= '1;
            else if (slot_o.kind == vic_pkg::VIC_LR && tick_q == 2'd1)
                refc_q <= refc_q - 1'b1;   // after each refresh
        end
    end

    // access schedule
    always_comb begin
        slot_o             = '0;
        slot_o.tick        = tick_q;
        slot_o.cycle       = cyc_q;
        slot_o.refc        = refc_q;
        slot_o.spr_en      = regs_i.spr_en;
        slot_o.bad_line    = bad_line;
        slot_o.line_start  = (cyc_q == '0) && (tick_q == '0);
        slot_o.frame_start = slot_o.line_start && (line_q == '0);
        slot_o.kind        = vic_pkg::VIC_NONE;

        if (spr_range)
            slot_o.sprite = spr_off[3:1];

        if (!tick_q[1]) begin
            if (cyc_q <= vic_pkg::REF_LAST)
                slot_o.kind = vic_pkg::VIC_LR;
            else if (cyc_q >= vic_pkg::G_FIRST && cyc_q <= vic_pkg::G_LAST)
                slot_o.kind = vic_pkg::VIC_LG;
            else if (spr_range)
                slot_o.kind = spr_off[0] ? vic_pkg::VIC_LS2 : vic_pkg::VIC_LP;
        end else begin
            if (bad_line && cyc_q >= vic_pkg::C_FIRST && cyc_q <= vic_pkg::C_LAST)
                slot_o.kind = vic_pkg::VIC_HRC;
            else if (spr_range)
                slot_o.kind = spr_off[0] ? vic_pkg::VIC_HS3 : vic_pkg::VIC_HS1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vic_matrix_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_matrix_fetch (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire vic_pkg::slot_s  slot_i,
    input  wire vic_pkg::data_t  data_i,
    output vic_pkg::vc_t         vc_o,
    output vic_pkg::rc_t         rc_o,
    output vic_pkg::data_t       char_ptr_o,
    output logic                 idle_o
);

    vic_pkg::data_t cbuf [vic_pkg::NUM_COLS];
    vic_pkg::col_t  vmli_q;
    vic_pkg::vc_t   vc_q;
    vic_pkg::vc_t   vc_base_q;
    vic_pkg::rc_t   rc_q;
    logic           display_q;
    logic           c_sample_q;   // c-access column is on the bus
    logic           g_done;
    logic           reload;
    logic           rc_step;

    // counters move on the edge that registers the column half
    assign g_done  = (slot_i.kind == vic_pkg::VIC_LG) && (slot_i.tick == 2'd1);
    assign reload  = slot_i.bad_line && (slot_i.tick == 2'd3)
                  && (slot_i.cycle == vic_pkg::VC_RELOAD_CYCLE);
    assign rc_step = (slot_i.tick == 2'd3) && (slot_i.cycle == vic_pkg::RC_STEP_CYCLE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            c_sample_q <= 1'b0;
            vmli_q     <= '0;
            vc_q       <= '0;
            vc_base_q  <= '0;
            rc_q       <= '0;
            display_q  <= 1'b0;
        end else begin
            c_sample_q <= (slot_i.kind == vic_pkg::VIC_HRC) && (slot_i.tick == 2'd3);

            if (slot_i.line_start)
                vmli_q <= '0;
            else if (g_done)
                vmli_q <= vmli_q + 1'b1;

            if (reload) begin
                vc_q <= vc_base_q;
                rc_q <= '0;
            end else begin
                if (g_done && display_q)
                    vc_q <= vc_q + 1'b1;
                if (rc_step)
                    rc_q <= rc_q + 1'b1;   // 7 wraps to 0
            end

            if (slot_i.frame_start)
                vc_base_q <= '0;
            else if (rc_step)
                vc_base_q <= vc_q;

            if (slot_i.bad_line)
                display_q <= 1'b1;
            else if (rc_step && rc_q == 3'd7)
                display_q <= 1'b0;   // back to idle
        end
    end

    always_ff @(posedge clk_i) begin
        if (c_sample_q)
            cbuf[vmli_q] <= data_i;
    end

    // pointer fetched in the previous phi2 is still on data_i
    assign char_ptr_o = c_sample_q ? data_i : cbuf[vmli_q];
    assign vc_o       = vc_q;
    assign rc_o       = rc_q;
    assign idle_o     = !display_q;

endmodule

`default_nettype wire

// ==== rtl/vic_sprite_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_sprite_dma (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire vic_pkg::slot_s      slot_i,
    input  wire vic_pkg::vic_regs_s  regs_i,
    input  wire vic_pkg::data_t      data_i,
    output vic_pkg::sprite_ptr_t     sprite_ptr_o,
    output vic_pkg::sprite_mc_t      sprite_mc_o,
    output logic                     owns_phi2_o
);

    vic_pkg::sprite_ptr_t ptr_q [vic_pkg::NUM_SPRITES];
    vic_pkg::sprite_mc_t  mc_q  [vic_pkg::NUM_SPRITES];
    vic_pkg::sprite_idx_t p_spr_q;
    logic                 p_sample_q;
    logic                 spr_on;
    logic                 s_kind;
    logic                 s_done;

    assign spr_on = regs_i.spr_en[slot_i.sprite];
    assign s_kind = (slot_i.kind == vic_pkg::VIC_HS1)
                 || (slot_i.kind == vic_pkg::VIC_LS2)
                 || (slot_i.kind == vic_pkg::VIC_HS3);
    assign s_done = s_kind && slot_i.tick[0] && spr_on;   // column tick of an s-access

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p_sample_q <= 1'b0;
            p_spr_q    <= '0;
            for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
                mc_q[i] <= '0;
        end else begin
            p_sample_q <= (slot_i.kind == vic_pkg::VIC_LP) && (slot_i.tick == 2'd1);
            p_spr_q    <= slot_i.sprite;

            if (slot_i.frame_start) begin
                for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
                    mc_q[i] <= '0;
            end else if (s_done) begin
                mc_q[slot_i.sprite] <= mc_q[slot_i.sprite] + 1'b1;   // mod 64
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (p_sample_q)
            ptr_q[p_spr_q] <= data_i;
    end

    // HS1 follows its p-access directly, pointer still on data_i
    assign sprite_ptr_o = p_sample_q ? data_i : ptr_q[slot_i.sprite];
    assign sprite_mc_o  = mc_q[slot_i.sprite];

    assign owns_phi2_o = spr_on && ((slot_i.kind == vic_pkg::VIC_HS1)
                                 || (slot_i.kind == vic_pkg::VIC_HS3));

endmodule

`default_nettype wire

// ==== rtl/vic_addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_addr_gen (
    input  wire vic_pkg::slot_s        slot_i,
    input  wire vic_pkg::vic_regs_s    regs_i,
    input  wire vic_pkg::vc_t          vc_i,
    input  wire vic_pkg::rc_t          rc_i,
    input  wire vic_pkg::data_t        char_ptr_i,
    input  wire logic                  idle_i,
    input  wire vic_pkg::sprite_ptr_t  sprite_ptr_i,
    input  wire vic_pkg::sprite_mc_t   sprite_mc_i,
    input  wire logic                  owns_phi2_i,
    output vic_pkg::dram_addr_t        vic_row_o,
    output vic_pkg::dram_addr_t        vic_col_o
);

    vic_pkg::vic_addr_t vic_addr;
    vic_pkg::vic_addr_t idle_addr;
    logic               s_on;

    assign idle_addr = regs_i.ecm ? vic_pkg::IDLE_ECM_ADDR : vic_pkg::IDLE_ADDR;

    // LS2 sits in phi1, so its enable is not covered by owns_phi2_i
    assign s_on = owns_phi2_i
               || ((slot_i.kind == vic_pkg::VIC_LS2) && regs_i.spr_en[slot_i.sprite]);

    always_comb begin
        vic_addr = vic_pkg::IDLE_ADDR;
        case (slot_i.kind)
            vic_pkg::VIC_LR: begin
                vic_addr = {6'h3f, slot_i.refc};
            end
            vic_pkg::VIC_LG: begin
                if (idle_i) begin
                    vic_addr = idle_addr;
                end else begin
                    if (regs_i.bmm)
                        vic_addr = {regs_i.cb[2], vc_i, rc_i};   // bitmap
                    else
                        vic_addr = {regs_i.cb, char_ptr_i, rc_i}; // char gen
                    if (regs_i.ecm)
                        vic_addr[10:9] = 2'b00;
                end
            end
            vic_pkg::VIC_HRC: begin
                vic_addr = {regs_i.vm, vc_i};
            end
            vic_pkg::VIC_LP: begin
                vic_addr = {regs_i.vm, 7'h7f, slot_i.sprite};
            end
            vic_pkg::VIC_HS1, vic_pkg::VIC_LS2, vic_pkg::VIC_HS3: begin
                vic_addr = s_on ? {sprite_ptr_i, sprite_mc_i} : idle_addr;
            end
            default: begin
                vic_addr = vic_pkg::IDLE_ADDR;
            end
        endcase
    end

    assign vic_row_o = vic_pkg::dram_row(vic_addr);
    assign vic_col_o = vic_pkg::dram_col(vic_addr);

endmodule

`default_nettype wire

// ==== rtl/vic_bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_bus_arbiter (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire vic_pkg::slot_s       slot_i,
    input  wire logic                 owns_phi2_i,
    input  wire vic_pkg::dram_addr_t  vic_row_i,
    input  wire vic_pkg::dram_addr_t  vic_col_i,
    input  wire vic_pkg::vic_addr_t   cpu_addr_i,
    output vic_pkg::dram_addr_t       ado_o,
    output logic                      aec_o,
    output logic                      ba_o
);

    vic_pkg::dram_addr_t ado_d;
    logic                vic_owns;
    logic                ba_req;

    assign vic_owns = slot_i.tick[1]
                   && ((slot_i.kind == vic_pkg::VIC_HRC) || owns_phi2_i);

    always_comb begin
        case (slot_i.tick)
            2'd0:    ado_d = vic_row_i;
            2'd1:    ado_d = vic_col_i;
            2'd2:    ado_d = vic_owns ? vic_row_i : vic_pkg::dram_row(cpu_addr_i);
            default: ado_d = vic_owns ? vic_col_i : vic_pkg::dram_col(cpu_addr_i);
        endcase
    end

    // each stolen phi2 in cycle k holds ba low over k-BA_LEAD .. k
    always_comb begin
        ba_req = slot_i.bad_line
              && (slot_i.cycle >= vic_pkg::C_FIRST - vic_pkg::BA_LEAD)
              && (slot_i.cycle <= vic_pkg::C_LAST);
        for (int s = 0; s < vic_pkg::NUM_SPRITES; s++) begin
            if (slot_i.spr_en[s]
                && (slot_i.cycle >= vic_pkg::SPR_FIRST + 2 * s - vic_pkg::BA_LEAD)
                && (slot_i.cycle <= vic_pkg::SPR_FIRST + 2 * s + 1))
                ba_req = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ado_o <= '0;
            aec_o <= 1'b1;
            ba_o  <= 1'b1;
        end else begin
            ado_o <= ado_d;
            aec_o <= !vic_owns;
            ba_o  <= !ba_req;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vic_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vic_mem_top #(
    parameter int NUM_LINES  = 312,
    parameter int DISP_FIRST = 48,
    parameter int DISP_LAST  = 247
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire vic_pkg::vic_regs_s  regs_i,
    input  wire vic_pkg::vic_addr_t  cpu_addr_i,
    input  wire vic_pkg::data_t      data_i,
    output vic_pkg::dram_addr_t      ado_o,
    output logic                     aec_o,
    output logic                     ba_o
);

    vic_pkg::slot_s       slot;
    vic_pkg::vc_t         vc;
    vic_pkg::rc_t         rc;
    vic_pkg::data_t       char_ptr;
    logic                 idle;
    vic_pkg::sprite_ptr_t sprite_ptr;
    vic_pkg::sprite_mc_t  sprite_mc;
    logic                 owns_phi2;
    vic_pkg::dram_addr_t  vic_row;
    vic_pkg::dram_addr_t  vic_col;

    vic_cycle_seq #(
        .NUM_LINES  (NUM_LINES),
        .DISP_FIRST (DISP_FIRST),
        .DISP_LAST  (DISP_LAST)
    ) u_seq (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .regs_i  (regs_i),
        .slot_o  (slot)
    );

    vic_matrix_fetch u_matrix (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .slot_i     (slot),
        .data_i     (data_i),
        .vc_o       (vc),
        .rc_o       (rc),
        .char_ptr_o (char_ptr),
        .idle_o     (idle)
    );

    vic_sprite_dma u_sprite (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .slot_i       (slot),
        .regs_i       (regs_i),
        .data_i       (data_i),
        .sprite_ptr_o (sprite_ptr),
        .sprite_mc_o  (sprite_mc),
        .owns_phi2_o  (owns_phi2)
    );

    vic_addr_gen u_addr (
        .slot_i       (slot),
        .regs_i       (regs_i),
        .vc_i         (vc),
        .rc_i         (rc),
        .char_ptr_i   (char_ptr),
        .idle_i       (idle),
        .sprite_ptr_i (sprite_ptr),
        .sprite_mc_i  (sprite_mc),
        .owns_phi2_i  (owns_phi2),
        .vic_row_o    (vic_row),
        .vic_col_o    (vic_col)
    );

    // shared address bus
    vic_bus_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .slot_i      (slot),
        .owns_phi2_i (owns_phi2),
        .vic_row_i   (vic_row),
        .vic_col_i   (vic_col),
        .cpu_addr_i  (cpu_addr_i),
        .ado_o       (ado_o),
        .aec_o       (aec_o),
        .ba_o        (ba_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_vic_model.svh ====
`ifndef TB_VIC_MODEL_SVH
`define TB_VIC_MODEL_SVH

int                   m_tick;
int                   m_cycle;
int                   m_line;
vic_pkg::refc_t       m_refc;
vic_pkg::vc_t         m_vc;
vic_pkg::vc_t         m_vc_base;
vic_pkg::rc_t         m_rc;
logic                 m_display;
vic_pkg::data_t       m_cbuf [vic_pkg::NUM_COLS];
vic_pkg::sprite_ptr_t m_ptr  [vic_pkg::NUM_SPRITES];
vic_pkg::sprite_mc_t  m_mc   [vic_pkg::NUM_SPRITES];

function automatic vic_pkg::dram_addr_t split_row(input vic_pkg::vic_addr_t a);
    return {a[11:8], 2'b11, a[13:8]};
endfunction

function automatic vic_pkg::dram_addr_t split_col(input vic_pkg::vic_addr_t a);
    return {a[11:8], a[7:0]};
endfunction

// memory contents: low byte xor high bits
function automatic vic_pkg::data_t mem_data(input vic_pkg::vic_addr_t a);
    return a[7:0] ^ {2'b00, a[13:8]};
endfunction

function automatic logic model_frame_start();
    return (m_line == 0) && (m_cycle == 0) && (m_tick == 0);
endfunction

function automatic logic model_bad_line(input vic_pkg::vic_regs_s r);
    return r.den && (m_line >= DISP_FIRST) && (m_line <= DISP_LAST)
        && (m_line[2:0] == r.yscroll);
endfunction

function automatic vic_pkg::sprite_idx_t sprite_of(input int c);
    return (c >= 46 && c <= 61) ? vic_pkg::sprite_idx_t'((c - 46) / 2) : '0;
endfunction

// phi2 of cycle c taken from the CPU
function automatic logic stolen(input vic_pkg::vic_regs_s r, input int c);
    if (model_bad_line(r) && c >= 4 && c <= 43)
        return 1'b1;
    if (c >= 46 && c <= 61)
        return r.spr_en[sprite_of(c)];
    return 1'b0;
endfunction

function automatic vic_pkg::cycle_kind_e model_kind(input vic_pkg::vic_regs_s r);
    if (m_tick < 2) begin
        if (m_cycle <= 4)
            return vic_pkg::VIC_LR;
        if (m_cycle <= 44)
            return vic_pkg::VIC_LG;
        if (m_cycle >= 46 && m_cycle <= 61)
            return (m_cycle % 2 == 0) ? vic_pkg::VIC_LP : vic_pkg::VIC_LS2;
        return vic_pkg::VIC_NONE;
    end
    if (model_bad_line(r) && m_cycle >= 4 && m_cycle <= 43)
        return vic_pkg::VIC_HRC;
    if (m_cycle >= 46 && m_cycle <= 61)
        return (m_cycle % 2 == 0) ? vic_pkg::VIC_HS1 : vic_pkg::VIC_HS3;
    return vic_pkg::VIC_NONE;
endfunction

function automatic vic_pkg::vic_addr_t model_vic_addr(input vic_pkg::vic_regs_s r);
    vic_pkg::vic_addr_t   a;
    vic_pkg::vic_addr_t   idle_a;
    vic_pkg::sprite_idx_t s;
    idle_a = r.ecm ? 14'h39ff : 14'h3fff;
    s = sprite_of(m_cycle);
    case (model_kind(r))
        vic_pkg::VIC_LR:  a = {6'h3f, m_refc};
        vic_pkg::VIC_HRC: a = {r.vm, m_vc};
        vic_pkg::VIC_LP:  a = {r.vm, 7'h7f, s};
        vic_pkg::VIC_LG: begin
            if (!m_display) begin
                a = idle_a;
            end else begin
                if (r.bmm)
                    a = {r.cb[2], m_vc, m_rc};
                else
                    a = {r.cb, m_cbuf[6'(m_cycle - 5)], m_rc};
                if (r.ecm)
                    a[10:9] = 2'b00;
            end
        end
        vic_pkg::VIC_NONE: a = 14'h3fff;
        default: a = r.spr_en[s] ? {m_ptr[s], m_mc[s]} : idle_a;   // s-accesses
    endcase
    return a;
endfunction

function automatic void model_reset();
    m_tick    = 0;
    m_cycle   = 0;
    m_line    = 0;
    m_refc    = 8'hff;
    m_vc      = '0;
    m_vc_base = '0;
    m_rc      = '0;
    m_display = 1'b0;
    for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
        m_mc[i] = '0;
endfunction

// state change on the clock edge that ends the current tick
function automatic void model_step(input vic_pkg::vic_regs_s r);
    vic_pkg::cycle_kind_e kind;
    vic_pkg::vic_addr_t   a;
    vic_pkg::sprite_idx_t s;
    vic_pkg::vc_t         vc_old;
    vic_pkg::rc_t         rc_old;
    logic                 bl;
    logic                 rc_step;
    logic                 fs;
    kind    = model_kind(r);
    a       = model_vic_addr(r);
    s       = sprite_of(m_cycle);
    bl      = model_bad_line(r);
    fs      = model_frame_start();
    rc_step = (m_cycle == 58) && (m_tick == 3);
    vc_old  = m_vc;
    rc_old  = m_rc;

    if (kind == vic_pkg::VIC_LR && m_tick == 1)
        m_refc = m_refc - 8'd1;
    if (kind == vic_pkg::VIC_HRC && m_tick == 3)
        m_cbuf[6'(m_cycle - 4)] = mem_data(a);
    if (kind == vic_pkg::VIC_LP && m_tick == 1)
        m_ptr[s] = mem_data(a);

    if (bl && m_cycle == 14 && m_tick == 3) begin
        m_vc = m_vc_base;
        m_rc = '0;
    end else begin
        if (kind == vic_pkg::VIC_LG && m_tick == 1 && m_display)
            m_vc = m_vc + 10'd1;
        if (rc_step)
            m_rc = m_rc + 3'd1;
    end
    if (fs)
        m_vc_base = '0;
    else if (rc_step)
        m_vc_base = vc_old;
    if (bl)
        m_display = 1'b1;
    else if (rc_step && rc_old == 3'd7)
        m_display = 1'b0;

    if (fs) begin
        for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
            m_mc[i] = '0;
    end else if ((kind == vic_pkg::VIC_HS1 || kind == vic_pkg::VIC_LS2
                  || kind == vic_pkg::VIC_HS3) && (m_tick % 2 == 1) && r.spr_en[s]) begin
        m_mc[s] = m_mc[s] + 6'd1;
    end

    m_tick++;
    if (m_tick == 4) begin
        m_tick = 0;
        m_cycle++;
        if (m_cycle == vic_pkg::CYCLES_PER_LINE) begin
            m_cycle = 0;
            m_line++;
            if (m_line == LINES) begin
                m_line = 0;
                m_refc = 8'hff;   // new frame
            end
        end
    end
endfunction

`endif

// ==== tb/tb_vic_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vic_mem;

    localparam int LINES       = 24;
    localparam int DISP_FIRST  = 2;
    localparam int DISP_LAST   = 17;
    localparam int FRAMES      = 8;
    localparam int FRAME_TICKS = LINES * vic_pkg::CYCLES_PER_LINE * 4;

    localparam int T_REFRESH = 0;
    localparam int T_MATRIX  = 1;
    localparam int T_MODES   = 2;
    localparam int T_SPRITE  = 3;
    localparam int T_BUS     = 4;
    localparam int T_RESET   = 5;

    logic                clk;
    logic                rst_n;
    vic_pkg::vic_regs_s  regs;
    vic_pkg::vic_addr_t  cpu_addr;
    vic_pkg::data_t      data;
    vic_pkg::dram_addr_t ado;
    logic                aec;
    logic                ba;

    logic [31:0]         lfsr_q;
    vic_pkg::dram_addr_t row_seen;
    logic                first_tick;
    int                  checks [6];
    int                  errors [6];
    int                  at_line;
    int                  at_cycle;
    int                  at_tick;

    `include "tb_vic_model.svh"

    vic_mem_top #(
        .NUM_LINES  (LINES),
        .DISP_FIRST (DISP_FIRST),
        .DISP_LAST  (DISP_LAST)
    ) UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .regs_i     (regs),
        .cpu_addr_i (cpu_addr),
        .data_i     (data),
        .ado_o      (ado),
        .aec_o      (aec),
        .ba_o       (ba)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic vic_pkg::vic_regs_s random_regs();
        vic_pkg::vic_regs_s r;
        r.vm      = 4'(rand_bits(4));
        r.cb      = 3'(rand_bits(3));
        r.bmm     = lfsr_bit();
        r.ecm     = lfsr_bit();
        r.den     = (rand_bits(2) != 0);   // on most frames
        r.yscroll = 3'(rand_bits(3));
        r.spr_en  = 8'(rand_bits(8));
        return r;
    endfunction

    function automatic string test_label(input int t);
        case (t)
            T_REFRESH: return "refresh";
            T_MATRIX:  return "matrix fetch";
            T_MODES:   return "modes and idle";
            T_SPRITE:  return "sprite dma";
            T_BUS:     return "cpu phases and ba";
            default:   return "reset";
        endcase
    endfunction

    function automatic int test_of_slot(input vic_pkg::vic_regs_s r);
        case (model_kind(r))
            vic_pkg::VIC_LR:   return T_REFRESH;
            vic_pkg::VIC_HRC:  return T_MATRIX;
            vic_pkg::VIC_LG:   return (m_display && !r.bmm && !r.ecm) ? T_MATRIX : T_MODES;
            vic_pkg::VIC_NONE: return (m_tick >= 2) ? T_BUS : T_MODES;
            default:           return T_SPRITE;
        endcase
    endfunction

    task automatic check_ado(input int t, input vic_pkg::dram_addr_t exp_v,
                             input vic_pkg::dram_addr_t act_v);
        checks[t]++;
        if (act_v !== exp_v) begin
            errors[t]++;
            $display("[ERROR] %s: ado_o expected %h actual %h at line %0d cycle %0d tick %0d",
                     test_label(t), exp_v, act_v, at_line, at_cycle, at_tick);
        end
    endtask

    task automatic check_level(input int t, input string sig, input logic exp_v,
                               input logic act_v);
        checks[t]++;
        if (act_v !== exp_v) begin
            errors[t]++;
            $display("[ERROR] %s: %s expected %b actual %b at line %0d cycle %0d tick %0d",
                     test_label(t), sig, exp_v, act_v, at_line, at_cycle, at_tick);
        end
    endtask

    // even ticks put a row on the bus, odd ticks a column
    task automatic respond_memory(input int shown_tick);
        if (shown_tick % 2 == 0)
            row_seen = ado;
        else
            data = mem_data({row_seen[5:4], ado});
    endtask

    task automatic run_tick();
        vic_pkg::vic_addr_t  a;
        vic_pkg::dram_addr_t exp_ado;
        logic                exp_aec;
        logic                exp_ba;
        logic                owns;
        int                  t;
        if (model_frame_start())
            regs = random_regs();
        cpu_addr = vic_pkg::vic_addr_t'(rand_bits(14));
        a    = model_vic_addr(regs);
        owns = (m_tick >= 2) && stolen(regs, m_cycle);
        case (m_tick)
            0:       exp_ado = split_row(a);
            1:       exp_ado = split_col(a);
            2:       exp_ado = owns ? split_row(a) : split_row(cpu_addr);
            default: exp_ado = owns ? split_col(a) : split_col(cpu_addr);
        endcase
        exp_aec = !owns;
        exp_ba  = 1'b1;
        for (int j = m_cycle; j <= m_cycle + 3; j++)
            if (stolen(regs, j))
                exp_ba = 1'b0;
        t        = first_tick ? T_RESET : test_of_slot(regs);
        at_line  = m_line;
        at_cycle = m_cycle;
        at_tick  = m_tick;
        model_step(regs);
        @(posedge clk);
        #1;
        respond_memory(at_tick);
        check_ado(t, exp_ado, ado);
        check_level(t, "aec_o", exp_aec, aec);
        check_level(first_tick ? T_RESET : T_BUS, "ba_o", exp_ba, ba);
        first_tick = 1'b0;
    endtask

    task automatic report_test(input int t);
        $display("test %s: %0d checks, %0d errors", test_label(t), checks[t], errors[t]);
    endtask

    initial begin
        int   n;
        int   ticks;
        int   total_checks;
        int   total_errors;
        logic timed_out;
        lfsr_q     = 32'h94a0_6465;
        rst_n      = 1'b0;
        regs       = '0;
        cpu_addr   = '0;
        data       = '0;
        row_seen   = '0;
        first_tick = 1'b1;
        timed_out  = 1'b0;
        at_line    = 0;
        at_cycle   = 0;
        at_tick    = 0;
        for (n = 0; n < 6; n++) begin
            checks[n] = 0;
            errors[n] = 0;
        end

        for (n = 0; n < 5; n++)
            @(posedge clk);
        #1;
        check_level(T_RESET, "aec_o", 1'b1, aec);
        check_level(T_RESET, "ba_o", 1'b1, ba);
        check_ado(T_RESET, '0, ado);
        model_reset();
        rst_n = 1'b1;
        run_tick();   // first slot must show one clock later
        report_test(T_RESET);

        for (int f = 0; f < FRAMES; f++) begin
            ticks = 0;
            do begin
                run_tick();
                ticks++;
            end while (!model_frame_start() && ticks < FRAME_TICKS + 16);
            if (!model_frame_start()) begin
                $display("frame %0d did not reach the next frame start in %0d ticks", f, ticks);
                timed_out = 1'b1;
                break;
            end
        end

        total_checks = 0;
        total_errors = 0;
        for (n = 0; n < 6; n++) begin
            if (n != T_RESET)
                report_test(n);
            total_checks += checks[n];
            total_errors += errors[n];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
rtl/vic_pkg.sv
rtl/vic_cycle_seq.sv
rtl/vic_matrix_fetch.sv
rtl/vic_sprite_dma.sv
rtl/vic_addr_gen.sv
rtl/vic_bus_arbiter.sv
rtl/vic_mem_top.sv
tb/tb_vic_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the VIC memory fetch testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_vic_mem \
    -f vlog.f \
    -o sim_tb_vic_mem

./obj_dir/sim_tb_vic_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
